//--- include/mpu_settings.svh
// Matrix processing unit build settings
// Matrix dimensions, register count and float word width

`ifndef MPU_SETTINGS_SVH
`define MPU_SETTINGS_SVH

// ----------------------------------------------------------------------
// Matrix geometry
// ----------------------------------------------------------------------
`define MPU_M 4         // Max rows per matrix
`define MPU_N 4         // Max columns per matrix

// ----------------------------------------------------------------------
// Register file
// ----------------------------------------------------------------------
`define MPU_REGS 4      // Matrix registers

// Single precision word
`define MPU_FP_W 32

`endif

//--- verilog/mpu_pkg.sv
// Matrix processing unit shared types
// Float word view, element operation codes and index types

`include "mpu_settings.svh"

package mpu_pkg;

    // Index widths follow the geometry
    localparam int REG_IDX_W = $clog2(`MPU_REGS);
    localparam int ROW_IDX_W = $clog2(`MPU_M);
    localparam int COL_IDX_W = $clog2(`MPU_N);
    localparam int SIZE_M_W  = $clog2(`MPU_M + 1);  // Holds 1..M
    localparam int SIZE_N_W  = $clog2(`MPU_N + 1);  // Holds 1..N

    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [ROW_IDX_W-1:0] row_idx_t;
    typedef logic [COL_IDX_W-1:0] col_idx_t;
    typedef logic [SIZE_M_W-1:0]  size_m_t;
    typedef logic [SIZE_N_W-1:0]  size_n_t;

    // One float word, seen as raw bits or as IEEE fields
    typedef union packed {
        logic [`MPU_FP_W-1:0] raw;
        struct packed {
            logic        sign;
            logic [7:0]  exp;
            logic [22:0] man;
        } f;
    } float_sp;

    // Per-element operation on the store stream
    typedef enum logic [1:0] {
        OP_PASS  = 2'd0,
        OP_NEG   = 2'd1,
        OP_ABS   = 2'd2,
        OP_SCALE = 2'd3
    } elem_op_e;

endpackage : mpu_pkg

//--- verilog/mpu_reg_if.sv
// Register file port bundles
// Write side driven by the load unit, read side by the store unit

`timescale 1ns/10ps

interface mpu_wr_if;
    import mpu_pkg::*;

    logic     wr_en;        // Element write strobe
    reg_idx_t wr_addr;      // Target register
    row_idx_t wr_i;
    col_idx_t wr_j;
    float_sp  wr_data;
    logic     wr_last;      // Final element, frees the register
    size_m_t  wr_size_m;    // Latched on claim
    size_n_t  wr_size_n;
    logic     claim;        // Marks wr_addr as being written
    logic     load_ready;   // wr_addr free in both sets

    modport loader (
        output wr_en, wr_addr, wr_i, wr_j, wr_data, wr_last,
        output wr_size_m, wr_size_n, claim,
        input  load_ready
    );

    modport regfile (
        input  wr_en, wr_addr, wr_i, wr_j, wr_data, wr_last,
        input  wr_size_m, wr_size_n, claim,
        output load_ready
    );
endinterface : mpu_wr_if

interface mpu_rd_if;
    import mpu_pkg::*;

    logic     rd_en;        // Element read strobe
    reg_idx_t rd_addr;      // Source register
    row_idx_t rd_i;
    col_idx_t rd_j;
    logic     rd_last;      // Final element, frees the register
    logic     claim;        // Marks rd_addr as being read
    float_sp  rd_data;      // One cycle after rd_en
    size_m_t  rd_size_m;    // Stored size of rd_addr
    size_n_t  rd_size_n;
    logic     store_ready;  // rd_addr not being written

    modport storer (
        output rd_en, rd_addr, rd_i, rd_j, rd_last, claim,
        input  rd_size_m, rd_size_n, store_ready
    );

    modport regfile (
        input  rd_en, rd_addr, rd_i, rd_j, rd_last, claim,
        output rd_data, rd_size_m, rd_size_n, store_ready
    );
endinterface : mpu_rd_if

//--- verilog/mpu_register_file.sv
// Matrix register file
// Holds the matrices and their sizes, tracks which registers are in use

`timescale 1ns/10ps
`include "mpu_settings.svh"

module mpu_register_file (
    input logic       clk,
    input logic       rst,
    mpu_wr_if.regfile wr,
    mpu_rd_if.regfile rd
);
    import mpu_pkg::*;

    float_sp mem [`MPU_REGS][`MPU_M][`MPU_N];   // Element storage
    size_m_t size_m [`MPU_REGS];                // Rows per register
    size_n_t size_n [`MPU_REGS];                // Columns per register

    logic [`MPU_REGS-1:0] writing;              // One-hot, load in progress
    logic [`MPU_REGS-1:0] reading;              // One-hot, store in progress

    // ----------------------------------------------------------------------
    // Ready flags
    // ----------------------------------------------------------------------
    // Loads need the register idle both ways, stores only need no writer
    assign wr.load_ready  = ~(writing[wr.wr_addr] | reading[wr.wr_addr]);
    assign rd.store_ready = ~writing[rd.rd_addr];

    // Size of the register being read
    assign rd.rd_size_m = size_m[rd.rd_addr];
    assign rd.rd_size_n = size_n[rd.rd_addr];

    // ----------------------------------------------------------------------
    // Storage
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin : element_rw
        if (wr.wr_en) begin
            mem[wr.wr_addr][wr.wr_i][wr.wr_j].raw <= wr.wr_data.raw;
        end
        if (rd.rd_en) begin
            rd.rd_data.raw <= mem[rd.rd_addr][rd.rd_i][rd.rd_j].raw;   // Registered read
        end
    end : element_rw

    // Size captured once per load, at the claim
    always_ff @(posedge clk) begin : size_regs
        if (rst) begin
            for (int r = 0; r < `MPU_REGS; r++) begin
                size_m[r] <= size_m_t'(`MPU_M);   // Untouched reg reads as full
                size_n[r] <= size_n_t'(`MPU_N);
            end
        end else if (wr.claim) begin
            size_m[wr.wr_addr] <= wr.wr_size_m;
            size_n[wr.wr_addr] <= wr.wr_size_n;
        end
    end : size_regs

    // ----------------------------------------------------------------------
    // Busy sets
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin : write_set
        if (rst) begin
            writing <= '0;
        end else begin
            if (wr.wr_en && wr.wr_last) begin
                writing[wr.wr_addr] <= 1'b0;      // Last element landed
            end
            if (wr.claim) begin
                writing[wr.wr_addr] <= 1'b1;
            end
        end
    end : write_set

    always_ff @(posedge clk) begin : read_set
        if (rst) begin
            reading <= '0;
        end else begin
            if (rd.rd_en && rd.rd_last) begin
                reading[rd.rd_addr] <= 1'b0;      // Last element fetched
            end
            if (rd.claim) begin
                reading[rd.rd_addr] <= 1'b1;
            end
        end
    end : read_set

endmodule : mpu_register_file

//--- verilog/mpu_load_unit.sv
// Matrix load sequencer
// Takes one element per memory strobe into a register in row-major order

`timescale 1ns/10ps

module mpu_load_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              load_start,
    input  mpu_pkg::reg_idx_t load_reg,
    input  mpu_pkg::size_m_t  load_m,
    input  mpu_pkg::size_n_t  load_n,
    input  logic              mem_valid,
    input  mpu_pkg::float_sp  mem_data,
    output logic              load_done,
    output logic              load_reject,
    output logic              load_busy,
    mpu_wr_if.loader          wr
);
    import mpu_pkg::*;

    reg_idx_t addr_q;       // Register under load
    size_m_t  m_q;
    size_n_t  n_q;
    row_idx_t i_q;          // Current position
    col_idx_t j_q;
    logic     accept;
    logic     last_col;
    logic     last_row;

    assign accept   = load_start & ~load_busy & wr.load_ready;
    assign last_col = (size_n_t'(j_q) == n_q - size_n_t'(1));
    assign last_row = (size_m_t'(i_q) == m_q - size_m_t'(1));

    // ----------------------------------------------------------------------
    // Write port
    // ----------------------------------------------------------------------
    assign wr.claim     = accept;                             // Sets the writing bit
    assign wr.wr_addr   = load_busy ? addr_q : load_reg;      // Idle: ask about request
    assign wr.wr_en     = load_busy & mem_valid;
    assign wr.wr_i      = i_q;
    assign wr.wr_j      = j_q;
    assign wr.wr_data   = mem_data;
    assign wr.wr_last   = wr.wr_en & last_row & last_col;
    assign wr.wr_size_m = load_m;                             // Only used on claim
    assign wr.wr_size_n = load_n;

    // Command and element sequencing
    always_ff @(posedge clk) begin : ctrl
        if (rst) begin
            load_busy   <= 1'b0;
            load_done   <= 1'b0;
            load_reject <= 1'b0;
            i_q         <= '0;
            j_q         <= '0;
        end else begin
            load_done   <= 1'b0;
            load_reject <= load_start & ~accept;   // Busy or register in use
            if (accept) begin
                load_busy <= 1'b1;
                i_q       <= '0;
                j_q       <= '0;
            end else if (wr.wr_en) begin
                if (wr.wr_last) begin
                    load_busy <= 1'b0;
                    load_done <= 1'b1;
                end
                if (last_col) begin                // Wrap to next row
                    j_q <= '0;
                    i_q <= i_q + 1'b1;
                end else begin
                    j_q <= j_q + 1'b1;
                end
            end
        end
    end : ctrl

    // Command capture
    always_ff @(posedge clk) begin : cmd
        if (accept) begin
            addr_q <= load_reg;
            m_q    <= load_m;
            n_q    <= load_n;
        end
    end : cmd

endmodule : mpu_load_unit

//--- verilog/mpu_store_unit.sv
// Matrix store sequencer
// Walks a register in row-major order, one read per cycle

`timescale 1ns/10ps

module mpu_store_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               store_start,
    input  mpu_pkg::reg_idx_t  store_reg,
    input  mpu_pkg::elem_op_e  store_op,
    input  logic signed [3:0]  store_shift,
    output logic               store_reject,
    output logic               store_busy,
    output logic               op_valid,
    output logic               op_last,
    output mpu_pkg::elem_op_e  op_code,
    output logic signed [3:0]  op_shift,
    mpu_rd_if.storer           rd
);
    import mpu_pkg::*;

    reg_idx_t addr_q;
    size_m_t  m_q;
    size_n_t  n_q;
    row_idx_t i_q;
    col_idx_t j_q;
    logic     walking;      // Read phase
    logic     drain_q;      // Last element in the element stage
    logic     accept;
    logic     last_col;
    logic     last_row;

    assign accept   = store_start & ~store_busy & rd.store_ready;
    assign last_col = (size_n_t'(j_q) == n_q - size_n_t'(1));
    assign last_row = (size_m_t'(i_q) == m_q - size_m_t'(1));

    // ----------------------------------------------------------------------
    // Read port
    // ----------------------------------------------------------------------
    assign rd.claim   = accept;
    assign rd.rd_addr = store_busy ? addr_q : store_reg;
    assign rd.rd_en   = walking;
    assign rd.rd_i    = i_q;
    assign rd.rd_j    = j_q;
    assign rd.rd_last = walking & last_row & last_col;

    always_ff @(posedge clk) begin : ctrl
        if (rst) begin
            walking      <= 1'b0;
            store_busy   <= 1'b0;
            store_reject <= 1'b0;
            op_valid     <= 1'b0;
            op_last      <= 1'b0;
            drain_q      <= 1'b0;
            i_q          <= '0;
            j_q          <= '0;
        end else begin
            store_reject <= store_start & ~accept;
            op_valid     <= rd.rd_en;              // Aligned with rd_data
            op_last      <= rd.rd_last;
            drain_q      <= op_valid & op_last;    // Output stage holds last one
            if (accept) begin
                walking    <= 1'b1;
                store_busy <= 1'b1;
                i_q        <= '0;
                j_q        <= '0;
            end else begin
                if (drain_q) store_busy <= 1'b0;   // Falls after out_last
                if (walking) begin
                    if (rd.rd_last) walking <= 1'b0;
                    if (last_col) begin
                        j_q <= '0;
                        i_q <= i_q + 1'b1;
                    end else begin
                        j_q <= j_q + 1'b1;
                    end
                end
            end
        end
    end : ctrl

    // Command and stored size, held for the transfer
    always_ff @(posedge clk) begin : cmd
        if (accept) begin
            addr_q   <= store_reg;
            m_q      <= rd.rd_size_m;
            n_q      <= rd.rd_size_n;
            op_code  <= store_op;
            op_shift <= store_shift;
        end
    end : cmd

endmodule : mpu_store_unit

//--- verilog/mpu_element_op.sv
// Element operation stage
// One registered step of sign or exponent change per outgoing element

`timescale 1ns/10ps

module mpu_element_op (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  logic               in_last,
    input  mpu_pkg::float_sp   in_data,
    input  mpu_pkg::elem_op_e  op,
    input  logic signed [3:0]  shift,
    output logic               out_valid,
    output logic               out_last,
    output mpu_pkg::float_sp   out_data
);
    import mpu_pkg::*;

    logic signed [9:0] exp_sum;     // Room for under and overflow
    logic              exp_special; // Zero or inf/NaN
    float_sp           res;

    assign exp_sum     = $signed({2'b00, in_data.f.exp}) + {{6{shift[3]}}, shift};
    assign exp_special = (in_data.f.exp == 8'd0) || (in_data.f.exp == 8'hff);

    // ----------------------------------------------------------------------
    // Element rule
    // ----------------------------------------------------------------------
    always_comb begin
        res = in_data;
        case (op)
            OP_NEG: res.f.sign = ~in_data.f.sign;
            OP_ABS: res.f.sign = 1'b0;
            OP_SCALE: begin
                if (!exp_special) begin
                    if (exp_sum >= 10'sd255) begin
                        res.f.exp = 8'd254;            // Clamp below inf
                    end else if (exp_sum <= 10'sd0) begin
                        res.f.exp = 8'd1;              // Clamp above denormal
                    end else begin
                        res.f.exp = exp_sum[7:0];
                    end
                end
            end
            default: res = in_data;                    // OP_PASS
        endcase
    end

    always_ff @(posedge clk) begin : stage
        if (rst) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            out_valid <= in_valid;
            out_last  <= in_valid & in_last;
        end
        out_data <= res;
    end : stage

endmodule : mpu_element_op

//--- verilog/mpu_top.sv
// Matrix processing unit top
// Load and store paths around the matrix register file

`timescale 1ns/10ps
`include "mpu_settings.svh"

module mpu_top (
    input  logic                 clk,
    input  logic                 rst,
    // Load command and memory stream
    input  logic                 load_start,
    input  mpu_pkg::reg_idx_t    load_reg,
    input  mpu_pkg::size_m_t     load_m,
    input  mpu_pkg::size_n_t     load_n,
    input  logic                 mem_valid,
    input  logic [`MPU_FP_W-1:0] mem_data,
    output logic                 load_done,
    output logic                 load_reject,
    output logic                 load_busy,
    // Store command and output stream
    input  logic                 store_start,
    input  mpu_pkg::reg_idx_t    store_reg,
    input  mpu_pkg::elem_op_e    store_op,
    input  logic signed [3:0]    store_shift,
    output logic                 out_valid,
    output logic [`MPU_FP_W-1:0] out_data,
    output logic                 out_last,
    output mpu_pkg::size_m_t     out_m,
    output mpu_pkg::size_n_t     out_n,
    output logic                 store_reject,
    output logic                 store_busy
);
    import mpu_pkg::*;

    mpu_wr_if wr_if ();
    mpu_rd_if rd_if ();

    logic              op_valid;    // Register file data valid
    logic              op_last;
    elem_op_e          op_code;
    logic signed [3:0] op_shift;

    // Size of the register on the read side
    assign out_m = rd_if.rd_size_m;
    assign out_n = rd_if.rd_size_n;

    mpu_register_file u_regfile (
        .clk (clk),
        .rst (rst),
        .wr  (wr_if.regfile),
        .rd  (rd_if.regfile)
    );

    mpu_load_unit u_load (
        .clk         (clk),
        .rst         (rst),
        .load_start  (load_start),
        .load_reg    (load_reg),
        .load_m      (load_m),
        .load_n      (load_n),
        .mem_valid   (mem_valid),
        .mem_data    (mem_data),
        .load_done   (load_done),
        .load_reject (load_reject),
        .load_busy   (load_busy),
        .wr          (wr_if.loader)
    );

    mpu_store_unit u_store (
        .clk          (clk),
        .rst          (rst),
        .store_start  (store_start),
        .store_reg    (store_reg),
        .store_op     (store_op),
        .store_shift  (store_shift),
        .store_reject (store_reject),
        .store_busy   (store_busy),
        .op_valid     (op_valid),
        .op_last      (op_last),
        .op_code      (op_code),
        .op_shift     (op_shift),
        .rd           (rd_if.storer)
    );

    mpu_element_op u_elem (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (op_valid),
        .in_last   (op_last),
        .in_data   (rd_if.rd_data),
        .op        (op_code),
        .shift     (op_shift),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_data  (out_data)
    );

endmodule : mpu_top

//--- testbench/mpu_checker.sv
// Protocol checker for the matrix processing unit
// Bound to the top level, watches pulses, store latency and reset state

`timescale 1ns/10ps

module mpu_checker (
    input logic clk,
    input logic rst,
    input logic load_done,
    input logic load_reject,
    input logic load_busy,
    input logic store_start,
    input logic store_busy,
    input logic store_reject,
    input logic out_valid
);
    int unsigned fail_count = 0;    // Read by the testbench at the end

    // ----------------------------------------------------------------------
    // Store latency
    // ----------------------------------------------------------------------
    // Accepted start, then exactly two idle cycles before the first element
    a_out_latency: assert property (@(posedge clk) disable iff (rst)
        (store_start && !store_busy) ##1 !store_reject
            |-> !out_valid ##1 !out_valid ##1 out_valid)
        else begin
            $error("out_valid not 3 cycles after an accepted store_start");
            fail_count++;
        end

    // Output stream only inside a transfer
    a_valid_in_busy: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> store_busy)
        else begin
            $error("out_valid while store_busy is low");
            fail_count++;
        end

    // ----------------------------------------------------------------------
    // Single-cycle pulses
    // ----------------------------------------------------------------------
    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        load_done |=> !load_done)
        else begin
            $error("load_done longer than one cycle");
            fail_count++;
        end

    a_done_idle: assert property (@(posedge clk) disable iff (rst)
        load_done |-> !load_busy)       // Busy falls with done
        else begin
            $error("load_busy still high with load_done");
            fail_count++;
        end

    a_sreject_pulse: assert property (@(posedge clk) disable iff (rst)
        store_reject |=> !store_reject)
        else begin
            $error("store_reject longer than one cycle");
            fail_count++;
        end

    // Everything quiet once a reset cycle has passed
    a_reset_idle: assert property (@(posedge clk)
        rst |=> !(load_done || load_reject || load_busy ||
                  store_busy || store_reject || out_valid))
        else begin
            $error("outputs not idle after reset");
            fail_count++;
        end

endmodule : mpu_checker

bind mpu_top mpu_checker u_chk (
    .clk          (clk),
    .rst          (rst),
    .load_done    (load_done),
    .load_reject  (load_reject),
    .load_busy    (load_busy),
    .store_start  (store_start),
    .store_busy   (store_busy),
    .store_reject (store_reject),
    .out_valid    (out_valid)
);

//--- testbench/mpu_tb.sv
// Testbench for the matrix processing unit
// Loads matrices, stores them through the element stage, checks against a model

`timescale 1ns/10ps
`include "mpu_settings.svh"

module mpu_tb;
    import mpu_pkg::*;

    logic              clk;
    logic              rst;
    logic              load_start;
    reg_idx_t          load_reg;
    size_m_t           load_m;
    size_n_t           load_n;
    logic              mem_valid;
    logic [31:0]       mem_data;
    logic              load_done;
    logic              load_reject;
    logic              load_busy;
    logic              store_start;
    reg_idx_t          store_reg;
    elem_op_e          store_op;
    logic signed [3:0] store_shift;
    logic              out_valid;
    logic [31:0]       out_data;
    logic              out_last;
    size_m_t           out_m;
    size_n_t           out_n;
    logic              store_reject;
    logic              store_busy;

    // Reference copy of the registers, built from what was loaded
    logic [31:0] model [`MPU_REGS][`MPU_M][`MPU_N];
    int          model_m [`MPU_REGS];
    int          model_n [`MPU_REGS];
    logic [31:0] stim [$];          // Elements waiting to be loaded

    int    seed;
    int    errors;
    int    test_errs;
    int    tests_run;
    int    tests_passed;
    string test_name;

    mpu_top u_dut (.*);

    always #10 clk = ~clk;          // 20 ns period

    // ----------------------------------------------------------------------
    // Checks and reporting
    // ----------------------------------------------------------------------
    task automatic note_error();
        errors++;
        test_errs++;
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp)
        else begin
            $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
            note_error();
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond === 1'b1)
        else begin
            $display("ERROR in %s: %s", test_name, msg);
            note_error();
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errs == 0) begin
            tests_passed++;
            $display("%-22s passed", test_name);
        end else begin
            $display("%-22s failed with %0d errors", test_name, test_errs);
        end
    endtask

    // Expected element after the store stage
    function automatic logic [31:0] apply_rule(input logic [31:0] x, input elem_op_e op,
                                               input int shift);
        logic [31:0] y;
        int          e;
        y = x;
        e = x[30:23];
        case (op)
            OP_NEG:   y[31] = ~x[31];
            OP_ABS:   y[31] = 1'b0;
            OP_SCALE: begin
                if (e != 0 && e != 255) begin       // Zero and inf/NaN kept
                    e = e + shift;
                    if (e >= 255) e = 254;
                    else if (e <= 0) e = 1;
                    y[30:23] = e[7:0];
                end
            end
            default: y = x;
        endcase
        return y;
    endfunction

    task automatic push_random(input int count);
        repeat (count) stim.push_back($random(seed));
    endtask

    // ----------------------------------------------------------------------
    // Load side
    // ----------------------------------------------------------------------
    task automatic start_load(input int r, input int m, input int n, input bit expect_ok);
        @(posedge clk);
        load_start <= 1'b1;
        load_reg   <= reg_idx_t'(r);
        load_m     <= size_m_t'(m);
        load_n     <= size_n_t'(n);
        @(posedge clk);
        load_start <= 1'b0;
        @(negedge clk);
        check_value("load_reject", !expect_ok, load_reject);
        if (expect_ok) begin
            check_true(load_busy, "load_busy did not rise on an accepted load");
            model_m[r] = m;
            model_n[r] = n;
        end
    endtask

    // Streams m*n elements from stim, up to max_gap idle cycles between strobes
    task automatic stream_load(input int r, input int max_gap);
        int          k;
        int          n;
        int          gap;
        int          t;
        logic [31:0] w;
        n = model_n[r];
        for (k = 0; k < model_m[r] * n; k++) begin
            gap = $unsigned($random(seed)) % (max_gap + 1);
            repeat (gap) begin
                @(posedge clk);
                mem_valid <= 1'b0;
                @(negedge clk);
                check_true(!load_done, "load_done before the last element");
            end
            w = stim.pop_front();
            @(posedge clk);
            mem_valid <= 1'b1;
            mem_data  <= w;
            model[r][k / n][k % n] = w;
            @(negedge clk);
            check_true(!load_done, "load_done before the last element");
        end
        @(posedge clk);
        mem_valid <= 1'b0;
        @(negedge clk);
        for (t = 0; t < 20 && !load_done; t++) @(negedge clk);
        check_true(load_done, "timed out waiting for load_done");
        check_true(!load_busy, "load_busy still high after load_done");
    endtask

    // ----------------------------------------------------------------------
    // Store side
    // ----------------------------------------------------------------------
    task automatic start_store(input int r, input elem_op_e op, input int shift,
                               input bit expect_ok);
        @(posedge clk);
        store_start <= 1'b1;
        store_reg   <= reg_idx_t'(r);
        store_op    <= op;
        store_shift <= shift[3:0];
        @(posedge clk);
        store_start <= 1'b0;
        @(negedge clk);
        check_value("store_reject", !expect_ok, store_reject);
    endtask

    task automatic collect_store(input int r, input elem_op_e op, input int shift);
        int          k;
        int          t;
        int          n;
        logic [31:0] exp;
        n = model_n[r];
        for (t = 0; t < 10 && !out_valid; t++) @(negedge clk);
        check_true(out_valid, "timed out waiting for out_valid");
        if (out_valid) begin
            for (k = 0; k < model_m[r] * n; k++) begin
                exp = apply_rule(model[r][k / n][k % n], op, shift);
                check_true(out_valid, "gap in the out_valid stream");
                check_value("out_data", exp, out_data);
                check_value("out_last", (k == model_m[r] * n - 1), out_last);
                check_value("out_m", model_m[r], out_m);
                check_value("out_n", n, out_n);
                @(negedge clk);
            end
            check_true(!out_valid, "out_valid after the last element");
            check_true(!store_busy, "store_busy still high after out_last");
        end
    endtask

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------
    initial begin : main
        logic [31:0] specials [12];
        elem_op_e    ops [5];
        int          shifts [5];
        int          i;
        int          chk_fails;
        specials = '{32'h0000_0000, 32'h8000_0001,     // Exponent 0
                     32'h7f80_0000, 32'hffc0_1234,     // Exponent 255
                     32'h7f7f_ffff, 32'h7eff_ffff,     // Near the top
                     32'h7e00_0001, 32'h0080_0000,
                     32'h8100_0000, 32'h0200_0abc,     // Near the bottom
                     32'h3f80_0000, 32'hc040_0000};
        ops    = '{OP_NEG, OP_ABS, OP_SCALE, OP_SCALE, OP_SCALE};
        shifts = '{0, 0, 3, -5, 7};
        seed         = 32'hc36768d0;
        errors       = 0;
        tests_run    = 0;
        tests_passed = 0;
        clk          = 1'b0;
        rst          = 1'b1;
        load_start   = 1'b0;
        load_reg     = '0;
        load_m       = '0;
        load_n       = '0;
        mem_valid    = 1'b0;
        mem_data     = '0;
        store_start  = 1'b0;
        store_reg    = '0;
        store_op     = OP_PASS;
        store_shift  = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        begin_test("load_pass_store");
        push_random(16);
        start_load(0, 4, 4, 1);
        stream_load(0, 0);
        push_random(6);
        start_load(1, 2, 3, 1);
        stream_load(1, 0);
        start_store(0, OP_PASS, 0, 1);
        collect_store(0, OP_PASS, 0);
        start_store(1, OP_PASS, 0, 1);
        collect_store(1, OP_PASS, 0);
        end_test();

        begin_test("gapped_load");
        push_random(6);
        start_load(3, 3, 2, 1);
        stream_load(3, 3);
        start_store(3, OP_PASS, 0, 1);
        collect_store(3, OP_PASS, 0);
        end_test();

        begin_test("element_ops");
        for (i = 0; i < 12; i++) stim.push_back(specials[i]);
        push_random(4);
        start_load(2, 4, 4, 1);
        stream_load(2, 1);
        for (i = 0; i < 5; i++) begin
            start_store(2, ops[i], shifts[i], 1);
            collect_store(2, ops[i], shifts[i]);
        end
        end_test();

        begin_test("register_conflicts");
        push_random(16);
        start_load(2, 4, 4, 1);
        start_store(2, OP_PASS, 0, 0);      // Register being written
        start_load(3, 2, 2, 0);             // Load unit already busy
        stream_load(2, 0);
        start_store(2, OP_PASS, 0, 1);
        collect_store(2, OP_PASS, 0);
        start_store(3, OP_PASS, 0, 1);      // Size and data of reg 3 untouched
        collect_store(3, OP_PASS, 0);
        start_store(0, OP_PASS, 0, 1);
        fork
            collect_store(0, OP_PASS, 0);
            start_load(0, 4, 4, 0);         // Register being read
        join
        start_store(0, OP_PASS, 0, 1);
        collect_store(0, OP_PASS, 0);
        end_test();

        begin_test("concurrent_transfers");
        push_random(16);
        start_store(0, OP_NEG, 0, 1);
        fork
            collect_store(0, OP_NEG, 0);
            begin
                start_load(1, 4, 4, 1);
                stream_load(1, 1);
            end
        join
        start_store(1, OP_PASS, 0, 1);
        collect_store(1, OP_PASS, 0);
        end_test();

        begin_test("reset_mid_load");
        start_load(3, 4, 4, 1);
        repeat (5) begin
            @(posedge clk);
            mem_valid <= 1'b1;
            mem_data  <= $random(seed);
        end
        @(posedge clk);
        rst       <= 1'b1;
        mem_valid <= 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("idle outputs", 0, {load_busy, load_done, load_reject,
                                        store_busy, store_reject, out_valid});
        push_random(12);
        start_load(3, 3, 4, 1);             // Busy sets cleared by reset
        stream_load(3, 2);
        start_store(3, OP_ABS, 0, 1);
        collect_store(3, OP_ABS, 0);
        end_test();

        repeat (5) @(posedge clk);
        chk_fails = u_dut.u_chk.fail_count;
        $display("Summary: %0d run, %0d passed, %0d failed, %0d check errors, %0d assert errors",
                 tests_run, tests_passed, tests_run - tests_passed, errors, chk_fails);
        if (errors == 0 && chk_fails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end : main

endmodule : mpu_tb

//--- mpu.f
+incdir+include
verilog/mpu_pkg.sv
verilog/mpu_reg_if.sv
verilog/mpu_register_file.sv
verilog/mpu_load_unit.sv
verilog/mpu_store_unit.sv
verilog/mpu_element_op.sv
verilog/mpu_top.sv
testbench/mpu_checker.sv
testbench/mpu_tb.sv

//--- Bender.yml
package:
  name: mpu

sources:
  - include_dirs:
      - include
    files:
      - verilog/mpu_pkg.sv
      - verilog/mpu_reg_if.sv
      - verilog/mpu_register_file.sv
      - verilog/mpu_load_unit.sv
      - verilog/mpu_store_unit.sv
      - verilog/mpu_element_op.sv
      - verilog/mpu_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - testbench/mpu_checker.sv
      - testbench/mpu_tb.sv
